/* source/ddr_cmd_pkg.sv */
// DDR command definitions
// Command codes, the command word passed between the control blocks,
// and the SDRAM command pin bus

package ddr_cmd_pkg;

	//------------------------------------------------------------
	// Command codes
	//------------------------------------------------------------

	// Bits map straight onto {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		NOP = 3'b111,
		PRE = 3'b010,
		AR  = 3'b001,   // Auto refresh
		MRS = 3'b000,   // Mode register set, EMRS with BA 1
		ACT = 3'b011,
		RD  = 3'b101,
		WR  = 3'b100
	} ddr_cmd_e;

	//------------------------------------------------------------
	// Command word and pin bus
	//------------------------------------------------------------

	// Command, bank and address, 18 bits
	typedef struct packed {
		ddr_cmd_e    cmd;
		logic [1:0]  ba;
		logic [12:0] a;
	} ddr_cba_t;

	// Pins as seen by the SDRAM, 19 bits
	typedef struct packed {
		logic        cs_n;
		logic        ras_n;
		logic        cas_n;
		logic        we_n;
		logic [1:0]  ba;
		logic [12:0] a;
	} ddr_bus_t;

	// Deselected idle bus
	localparam ddr_bus_t bus_idle = '{cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1,
		we_n: 1'b1, ba: 2'b00, a: 13'h0000};

endpackage

/* source/ddr_mode_pkg.sv */
// DDR mode register definitions
// Field layout of the mode register, the two views of the address word
// and the mode values written during initialization

package ddr_mode_pkg;

	// MRS layout on A12..A0
	typedef struct packed {
		logic [3:0] reserved;      // A12..A9
		logic       dll_reset;     // A8
		logic       test_mode;     // A7
		logic [2:0] cas_latency;   // A6..A4
		logic       burst_type;    // A3, 0 = sequential
		logic [2:0] burst_len;     // A2..A0
	} mode_fields_t;

	// Address word, plain or mode register view
	typedef union packed {
		logic [12:0]  raw;
		mode_fields_t mode;
	} ddr_addr_u;

	//------------------------------------------------------------
	// Init mode words
	//------------------------------------------------------------

	// EMRS with A0 low enables the DLL, normal drive strength
	localparam logic [12:0] emrs_init = 13'h0000;

	// CL 2, sequential burst of 4, DLL reset
	localparam logic [12:0] mrs_init_dll = mode_fields_t'{reserved: 4'b0000,
		dll_reset: 1'b1, test_mode: 1'b0, cas_latency: 3'b010,
		burst_type: 1'b0, burst_len: 3'b010};

	// Same without DLL reset
	localparam logic [12:0] mrs_init_run = mode_fields_t'{reserved: 4'b0000,
		dll_reset: 1'b0, test_mode: 1'b0, cas_latency: 3'b010,
		burst_type: 1'b0, burst_len: 3'b010};

endpackage

/* source/ddr_init.sv */
// DDR power-up sequencer
// Waits out the stabilization delay in refresh ticks, then presents the
// seven initialization commands one after another on a valid/ready port

`timescale 1ns/10ps

module ddr_init
	import ddr_cmd_pkg::*, ddr_mode_pkg::*;
#(
	parameter logic [4:0] wait200_init = 5'd26
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     pulse78,
	output logic     wait200,
	output logic     init_done,
	output logic     init_valid,
	input  logic     init_ready,
	output ddr_cba_t init_cmd
);

	localparam logic [3:0] s_wait200 = 4'd0;
	localparam logic [3:0] s_pre1    = 4'd1;
	localparam logic [3:0] s_emrs    = 4'd2;
	localparam logic [3:0] s_mrs_dll = 4'd3;
	localparam logic [3:0] s_pre2    = 4'd4;
	localparam logic [3:0] s_ar1     = 4'd5;
	localparam logic [3:0] s_ar2     = 4'd6;
	localparam logic [3:0] s_mrs_run = 4'd7;
	localparam logic [3:0] s_done    = 4'd8;

	logic [4:0] wait_cnt;
	logic [3:0] state;
	logic       accept;

	//------------------------------------------------------------
	// Stabilization delay
	//------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wait200  <= 1'b1;
			wait_cnt <= wait200_init;
		end else begin
			if (wait_cnt == 5'd0)
				wait200 <= 1'b0;
			if (wait200 && pulse78 && wait_cnt != 5'd0)
				wait_cnt <= wait_cnt - 5'd1;
		end
	end

	//------------------------------------------------------------
	// Init sequence
	//------------------------------------------------------------

	assign accept     = init_valid & init_ready;
	assign init_valid = (state != s_wait200) && (state != s_done);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= s_wait200;
			init_done <= 1'b0;
		end else begin
			case (state)
				s_wait200: if (!wait200) state <= s_pre1;
				s_pre1:    if (accept) state <= s_emrs;
				s_emrs:    if (accept) state <= s_mrs_dll;
				s_mrs_dll: if (accept) state <= s_pre2;
				s_pre2:    if (accept) state <= s_ar1;
				s_ar1:     if (accept) state <= s_ar2;
				s_ar2:     if (accept) state <= s_mrs_run;
				s_mrs_run: begin
					if (accept) begin
						state     <= s_done;
						init_done <= 1'b1;
					end
				end
				default:   state <= s_done;
			endcase
		end
	end

	// Command for the current step
	always_comb begin
		init_cmd = '{cmd: NOP, ba: 2'b00, a: 13'h0000};
		case (state)
			s_pre1, s_pre2: begin
				init_cmd.cmd = PRE;
				init_cmd.a   = 13'h0400;   // A10, all banks
			end
			s_emrs: begin
				init_cmd.cmd = MRS;
				init_cmd.ba  = 2'b01;
				init_cmd.a   = emrs_init;
			end
			s_mrs_dll: begin
				init_cmd.cmd = MRS;
				init_cmd.a   = mrs_init_dll;
			end
			s_ar1, s_ar2: init_cmd.cmd = AR;
			s_mrs_run: begin
				init_cmd.cmd = MRS;
				init_cmd.a   = mrs_init_run;
			end
			default: ;
		endcase
	end

	// A held tick would shorten the power-up delay
	a_tick_pulse: assert property (@(posedge clk) disable iff (reset)
		pulse78 |=> !pulse78);

endmodule

/* source/ddr_refresh.sv */
// DDR refresh scheduler
// Produces the periodic refresh tick and keeps count of refreshes owed,
// requesting AR while any are owed and flagging urgency at four

`timescale 1ns/10ps

module ddr_refresh
	import ddr_cmd_pkg::*;
#(
	parameter logic [15:0] refresh_period = 16'd780
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     init_done,
	output logic     pulse78,
	output logic     ref_valid,
	output logic     ref_urgent,
	input  logic     ref_ready,
	output ddr_cba_t ref_cmd
);

	logic [15:0] period_cnt;
	logic [2:0]  owed_cnt;
	logic        tick;
	logic        ar_taken;

	// Period counter, one pulse per refresh_period cycles
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			period_cnt <= refresh_period - 16'd1;
			pulse78    <= 1'b0;
		end else if (period_cnt == 16'd0) begin
			period_cnt <= refresh_period - 16'd1;
			pulse78    <= 1'b1;
		end else begin
			period_cnt <= period_cnt - 16'd1;
			pulse78    <= 1'b0;
		end
	end

	//------------------------------------------------------------
	// Owed refresh count
	//------------------------------------------------------------

	assign tick     = pulse78 & init_done;
	assign ar_taken = ref_valid & ref_ready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			owed_cnt <= 3'd0;
		else if (tick && !ar_taken && owed_cnt != 3'd7)
			owed_cnt <= owed_cnt + 3'd1;   // Saturates at 7
		else if (ar_taken && !tick)
			owed_cnt <= owed_cnt - 3'd1;
	end

	assign ref_valid  = (owed_cnt != 3'd0);
	assign ref_urgent = owed_cnt[2];   // 4 or more
	assign ref_cmd    = '{cmd: AR, ba: 2'b00, a: 13'h0000};

	// A full count meeting another tick means refresh starvation
	a_ref_starve: assert property (@(posedge clk) disable iff (reset)
		tick && !ar_taken |-> owed_cnt != 3'd7);

endmodule

/* source/ddr_cmd_arbiter.sv */
// Command slot arbiter
// Picks init, refresh or user command for the next issue slot and
// routes the issuer's ready back to the chosen source only

`timescale 1ns/10ps

module ddr_cmd_arbiter
	import ddr_cmd_pkg::*;
(
	input  logic     init_done,
	input  logic     init_valid,
	input  ddr_cba_t init_cmd,
	output logic     init_ready,
	input  logic     ref_valid,
	input  logic     ref_urgent,
	input  ddr_cba_t ref_cmd,
	output logic     ref_ready,
	input  logic     user_valid,
	input  ddr_cba_t user_cmd,
	output logic     user_ready,
	output logic     issue_valid,
	output ddr_cba_t issue_cmd,
	input  logic     issue_ready
);

	logic gnt_init;
	logic gnt_ref;
	logic gnt_user;

	//------------------------------------------------------------
	// Priority select
	//------------------------------------------------------------

	// Init owns the slot until it is done
	assign gnt_init = ~init_done & init_valid;
	// Urgent refresh first, then user, then any owed refresh
	assign gnt_ref  = init_done & ref_valid & (ref_urgent | ~user_valid);
	assign gnt_user = init_done & user_valid & ~ref_urgent;

	assign issue_valid = gnt_init | gnt_ref | gnt_user;

	always_comb begin
		if (gnt_init)
			issue_cmd = init_cmd;
		else if (gnt_ref)
			issue_cmd = ref_cmd;
		else if (gnt_user)
			issue_cmd = user_cmd;
		else
			issue_cmd = '{cmd: NOP, ba: 2'b00, a: 13'h0000};
	end

	assign init_ready = gnt_init & issue_ready;
	assign ref_ready  = gnt_ref & issue_ready;
	assign user_ready = gnt_user & issue_ready;

	// An init step still pending at init_done would be dropped
	always_comb begin
		a_init_quiet: assert (!(init_done && init_valid))
			else $error("init command still pending after init_done");
	end

endmodule

/* source/ddr_cmd_issue.sv */
// DDR command issuer
// Drives each accepted command onto the pins for one cycle, NOP otherwise,
// and holds off the next command for the gap of the one just sent

`timescale 1ns/10ps

module ddr_cmd_issue
	import ddr_cmd_pkg::*, ddr_mode_pkg::*;
#(
	parameter logic [7:0] t_rp  = 8'd3,
	parameter logic [7:0] t_mrd = 8'd2,
	parameter logic [7:0] t_rfc = 8'd10,
	parameter logic [7:0] t_dll = 8'd200
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     issue_valid,
	input  ddr_cba_t issue_cmd,
	output logic     issue_ready,
	output ddr_bus_t ddr_bus
);

	logic [7:0] gap_cnt;
	logic [7:0] gap_len;
	logic       accept;
	ddr_addr_u  addr_view;

	assign issue_ready = (gap_cnt == 8'd0);
	assign accept      = issue_valid & issue_ready;
	assign addr_view   = issue_cmd.a;

	//------------------------------------------------------------
	// Gap per command type
	//------------------------------------------------------------

	always_comb begin
		case (issue_cmd.cmd)
			PRE: gap_len = t_rp;
			AR:  gap_len = t_rfc;
			MRS: begin
				// DLL relock only after a base MRS with A8 set
				if (issue_cmd.ba == 2'b00 && addr_view.mode.dll_reset)
					gap_len = t_dll;
				else
					gap_len = t_mrd;
			end
			default: gap_len = 8'd1;   // ACT, RD, WR
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			gap_cnt <= 8'd0;
		else if (accept)
			gap_cnt <= gap_len;
		else if (gap_cnt != 8'd0)
			gap_cnt <= gap_cnt - 8'd1;
	end

	//------------------------------------------------------------
	// Pin encoding
	//------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ddr_bus <= bus_idle;
		end else if (accept) begin
			ddr_bus.cs_n  <= 1'b0;
			ddr_bus.ras_n <= issue_cmd.cmd[2];
			ddr_bus.cas_n <= issue_cmd.cmd[1];
			ddr_bus.we_n  <= issue_cmd.cmd[0];
			ddr_bus.ba    <= issue_cmd.ba;
			ddr_bus.a     <= issue_cmd.a;
		end else begin
			ddr_bus <= bus_idle;   // One cycle only
		end
	end

	// Every command blocks at least the following slot
	a_gap_hold: assert property (@(posedge clk) disable iff (reset)
		accept |=> gap_cnt != 8'd0);

endmodule

/* source/ddr_mngt_top.sv */
// DDR command management top level
// Connects init sequencer, refresh scheduler, arbiter and issuer, and
// hands the timing parameters down to them

`timescale 1ns/10ps

module ddr_mngt_top
	import ddr_cmd_pkg::*;
#(
	parameter logic [4:0]  wait200_init   = 5'd26,
	parameter logic [15:0] refresh_period = 16'd780,
	parameter logic [7:0]  t_rp           = 8'd3,
	parameter logic [7:0]  t_mrd          = 8'd2,
	parameter logic [7:0]  t_rfc          = 8'd10,
	parameter logic [7:0]  t_dll          = 8'd200
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     user_valid,
	input  ddr_cba_t user_cmd,
	output logic     user_ready,
	output ddr_bus_t ddr_bus,
	output logic     init_done,
	output logic     wait200
);

	logic     pulse78;
	logic     init_valid, init_ready;
	logic     ref_valid, ref_ready, ref_urgent;
	logic     issue_valid, issue_ready;
	ddr_cba_t init_cmd, ref_cmd, issue_cmd;

	ddr_init #(.wait200_init(wait200_init)) u_init (
		.clk(clk), .reset(reset), .pulse78(pulse78), .wait200(wait200),
		.init_done(init_done), .init_valid(init_valid),
		.init_ready(init_ready), .init_cmd(init_cmd));

	ddr_refresh #(.refresh_period(refresh_period)) u_refresh (
		.clk(clk), .reset(reset), .init_done(init_done), .pulse78(pulse78),
		.ref_valid(ref_valid), .ref_urgent(ref_urgent),
		.ref_ready(ref_ready), .ref_cmd(ref_cmd));

	ddr_cmd_arbiter u_arbiter (
		.init_done(init_done), .init_valid(init_valid), .init_cmd(init_cmd),
		.init_ready(init_ready), .ref_valid(ref_valid), .ref_urgent(ref_urgent),
		.ref_cmd(ref_cmd), .ref_ready(ref_ready), .user_valid(user_valid),
		.user_cmd(user_cmd), .user_ready(user_ready),
		.issue_valid(issue_valid), .issue_cmd(issue_cmd),
		.issue_ready(issue_ready));

	ddr_cmd_issue #(.t_rp(t_rp), .t_mrd(t_mrd), .t_rfc(t_rfc), .t_dll(t_dll)) u_issue (
		.clk(clk), .reset(reset), .issue_valid(issue_valid),
		.issue_cmd(issue_cmd), .issue_ready(issue_ready), .ddr_bus(ddr_bus));

endmodule

/* bench/ddr_checker.sv */
// DDR pin checker
// Decodes the command pins and follows init order, user command order,
// command spacing and refresh accounting, counting what goes wrong

`timescale 1ns/10ps

module ddr_checker
	import ddr_cmd_pkg::*, ddr_mode_pkg::*;
#(
	parameter logic [15:0] refresh_period = 16'd60,
	parameter logic [7:0]  t_rp           = 8'd2,
	parameter logic [7:0]  t_mrd          = 8'd2,
	parameter logic [7:0]  t_rfc          = 8'd6,
	parameter logic [7:0]  t_dll          = 8'd20
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     user_valid,
	input  ddr_cba_t user_cmd,
	input  logic     user_ready,
	input  ddr_bus_t ddr_bus,
	input  logic     init_done,
	input  logic     wait200,
	output int       mismatches,
	output int       failures,
	output int       pending
);

	ddr_cba_t init_seq [0:6];
	ddr_cba_t user_q [$];      // Accepted user commands not yet on the pins
	ddr_cba_t seen;
	int       mism_cnt = 0;
	int       fail_cnt = 0;
	int       pend_cnt = 0;
	int       cmd_count = 0;
	int       cycle = 0;
	int       since_last = 0;
	int       last_gap = 0;
	int       ticks = 0;
	int       refreshes = 0;
	bit       ref_flagged = 1'b0;

	assign mismatches = mism_cnt;
	assign failures   = fail_cnt;
	assign pending    = pend_cnt;

	// JEDEC power-up order
	initial begin
		init_seq[0] = '{cmd: PRE, ba: 2'b00, a: 13'h0400};   // All banks
		init_seq[1] = '{cmd: MRS, ba: 2'b01, a: emrs_init};
		init_seq[2] = '{cmd: MRS, ba: 2'b00, a: mrs_init_dll};
		init_seq[3] = '{cmd: PRE, ba: 2'b00, a: 13'h0400};
		init_seq[4] = '{cmd: AR, ba: 2'b00, a: 13'h0000};
		init_seq[5] = '{cmd: AR, ba: 2'b00, a: 13'h0000};
		init_seq[6] = '{cmd: MRS, ba: 2'b00, a: mrs_init_run};
	end

	//------------------------------------------------------------
	// Pin decode and gap rules
	//------------------------------------------------------------

	// Deselect counts as NOP
	function automatic ddr_cba_t decode_pins(ddr_bus_t b);
		ddr_cba_t c;
		c.cmd = b.cs_n ? NOP : ddr_cmd_e'({b.ras_n, b.cas_n, b.we_n});
		c.ba  = b.ba;
		c.a   = b.a;
		return c;
	endfunction

	function automatic int gap_after(ddr_cba_t c);
		int gap;
		case (c.cmd)
			PRE:     gap = int'(t_rp);
			AR:      gap = int'(t_rfc);
			MRS:     gap = (c.ba == 2'b00 && c.a[8]) ? int'(t_dll) : int'(t_mrd);   // A8 DLL reset
			default: gap = 1;
		endcase
		return gap;
	endfunction

	function automatic string cmd_text(ddr_cba_t c);
		return $sformatf("%s ba %0d a %h", c.cmd.name(), c.ba, c.a);
	endfunction

	task automatic check_command(input ddr_cba_t c);
		ddr_cba_t exp_cmd;
		if (wait200) begin
			fail_cnt = fail_cnt + 1;
			$display("ERROR at %0t: command issued while wait200 is still high", $time);
		end
		if (cmd_count > 0 && since_last < last_gap + 1) begin
			mism_cnt = mism_cnt + 1;
			$display("MISMATCH at %0t: %s came %0d cycles after the previous command, needs %0d",
				$time, cmd_text(c), since_last, last_gap + 1);
		end
		if (cmd_count < 7) begin
			if (c != init_seq[cmd_count]) begin
				mism_cnt = mism_cnt + 1;
				$display("MISMATCH at %0t: init step %0d is %s, expected %s",
					$time, cmd_count, cmd_text(c), cmd_text(init_seq[cmd_count]));
			end
			if (cmd_count == 6 && !init_done) begin
				fail_cnt = fail_cnt + 1;
				$display("ERROR at %0t: init_done still low after the last init command", $time);
			end
		end else if (c.cmd == AR) begin
			refreshes = refreshes + 1;
		end else if (user_q.size() == 0) begin
			fail_cnt = fail_cnt + 1;
			$display("ERROR at %0t: %s on the pins was never accepted", $time, cmd_text(c));
		end else begin
			exp_cmd = user_q.pop_front();
			if (c != exp_cmd) begin
				mism_cnt = mism_cnt + 1;
				$display("MISMATCH at %0t: user command %s, expected %s",
					$time, cmd_text(c), cmd_text(exp_cmd));
			end
		end
		cmd_count  = cmd_count + 1;
		since_last = 0;
		last_gap   = gap_after(c);
	endtask

	//------------------------------------------------------------
	// Per-cycle monitor
	//------------------------------------------------------------

	always @(posedge clk) begin
		seen = decode_pins(ddr_bus);
		if (reset) begin
			if (seen.cmd != NOP || !wait200 || init_done) begin
				fail_cnt = fail_cnt + 1;
				$display("ERROR at %0t: pins or init flags not idle during reset", $time);
			end
		end else begin
			cycle      = cycle + 1;
			since_last = since_last + 1;
			// Tick is seen one edge after each full period
			if (cycle > 1 && cycle % int'(refresh_period) == 1 && init_done)
				ticks = ticks + 1;
			if (seen.cmd != NOP)
				check_command(seen);
			if (!ref_flagged && ticks - refreshes > 7) begin
				ref_flagged = 1'b1;
				fail_cnt    = fail_cnt + 1;
				$display("ERROR at %0t: refresh starvation, %0d ticks but only %0d refreshes",
					$time, ticks, refreshes);
			end else if (!ref_flagged && ticks < refreshes) begin
				ref_flagged = 1'b1;
				fail_cnt    = fail_cnt + 1;
				$display("ERROR at %0t: refresh issued while none was owed", $time);
			end
			if (user_valid && user_ready) begin
				if (!init_done) begin
					fail_cnt = fail_cnt + 1;
					$display("ERROR at %0t: user command granted before init_done", $time);
				end
				user_q.push_back(user_cmd);
			end
			pend_cnt = user_q.size();
		end
	end

endmodule

/* bench/ddr_tb.sv */
// DDR command core testbench
// Resets the core and feeds seeded random user commands through the
// valid/ready port while the pin checker does the comparing

`timescale 1ns/10ps

module ddr_tb
	import ddr_cmd_pkg::*;
();

	localparam logic [4:0]  wait200_init   = 5'd3;
	localparam logic [15:0] refresh_period = 16'd60;
	localparam logic [7:0]  t_rp           = 8'd2;
	localparam logic [7:0]  t_mrd          = 8'd2;
	localparam logic [7:0]  t_rfc          = 8'd6;
	localparam logic [7:0]  t_dll          = 8'd20;
	localparam int          num_cmds       = 200;
	localparam int          accept_limit   = 2000;   // Long enough to cover init
	localparam int          drain_limit    = 100;

	logic     clk;
	logic     reset;
	logic     user_valid;
	ddr_cba_t user_cmd;
	logic     user_ready;
	ddr_bus_t ddr_bus;
	logic     init_done;
	logic     wait200;
	int       mismatches;
	int       failures;
	int       pending;
	int       timeouts = 0;
	integer   seed = 32'h34b6_1cc4;

	always #50 clk = ~clk;

	ddr_mngt_top #(.wait200_init(wait200_init), .refresh_period(refresh_period),
		.t_rp(t_rp), .t_mrd(t_mrd), .t_rfc(t_rfc), .t_dll(t_dll)) dut (
		.clk(clk), .reset(reset), .user_valid(user_valid), .user_cmd(user_cmd),
		.user_ready(user_ready), .ddr_bus(ddr_bus), .init_done(init_done),
		.wait200(wait200));

	ddr_checker #(.refresh_period(refresh_period), .t_rp(t_rp), .t_mrd(t_mrd),
		.t_rfc(t_rfc), .t_dll(t_dll)) chk (
		.clk(clk), .reset(reset), .user_valid(user_valid), .user_cmd(user_cmd),
		.user_ready(user_ready), .ddr_bus(ddr_bus), .init_done(init_done),
		.wait200(wait200), .mismatches(mismatches), .failures(failures),
		.pending(pending));

	//------------------------------------------------------------
	// Stimulus tasks
	//------------------------------------------------------------

	// One random command, held until taken
	task automatic send_user_cmd(output bit timed_out);
		logic [31:0] rnd;
		int          waited;
		bit          taken;
		rnd       = $random(seed);
		timed_out = 1'b0;
		taken     = 1'b0;
		waited    = 0;
		if (rnd[19]) begin
			user_valid = 1'b0;   // Idle gap about half the time
			repeat (int'(rnd[18:17]) + 1) @(negedge clk);
		end
		case (rnd[1:0])
			2'd0:    user_cmd.cmd = ACT;
			2'd1:    user_cmd.cmd = RD;
			2'd2:    user_cmd.cmd = WR;
			default: user_cmd.cmd = PRE;
		endcase
		user_cmd.ba = rnd[3:2];
		user_cmd.a  = rnd[16:4];
		user_valid  = 1'b1;
		while (!taken && !timed_out) begin
			@(posedge clk);
			taken  = user_ready;
			waited = waited + 1;
			if (!taken && waited >= accept_limit) begin
				timed_out = 1'b1;
				$display("Timeout at %0t: user command not accepted within %0d cycles",
					$time, accept_limit);
			end
		end
		@(negedge clk);
	endtask

	task automatic wait_drain(output bit timed_out);
		int waited;
		waited    = 0;
		timed_out = 1'b0;
		while (pending != 0 && !timed_out) begin
			@(negedge clk);
			waited = waited + 1;
			if (pending != 0 && waited >= drain_limit) begin
				timed_out = 1'b1;
				$display("Timeout at %0t: accepted user commands never reached the pins", $time);
			end
		end
	endtask

	task automatic end_run();
		$display("Errors: %0d mismatches, %0d other failures, %0d timeouts",
			mismatches, failures, timeouts);
		if (mismatches + failures + timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	initial begin
		bit timed_out;
		int n;
		clk        = 1'b0;
		reset      = 1'b1;
		user_valid = 1'b0;
		user_cmd   = '{cmd: NOP, ba: 2'b00, a: 13'h0000};
		timed_out  = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		// Traffic starts at once and is held off by the arbiter until init ends
		for (n = 0; n < num_cmds && !timed_out; n++)
			send_user_cmd(timed_out);
		user_valid = 1'b0;
		if (!timed_out)
			wait_drain(timed_out);
		if (!timed_out)
			repeat (3 * refresh_period) @(negedge clk);   // Refresh only
		if (timed_out)
			timeouts = timeouts + 1;
		end_run();
	end

endmodule

/* flist.f */
source/ddr_cmd_pkg.sv
source/ddr_mode_pkg.sv
source/ddr_init.sv
source/ddr_refresh.sv
source/ddr_cmd_arbiter.sv
source/ddr_cmd_issue.sv
source/ddr_mngt_top.sv
bench/ddr_checker.sv
bench/ddr_tb.sv

/* run.sh */
#!/bin/sh
# Build and run ddr_tb with Verilator, then judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ddr_tb -f flist.f -o ddr_sim \
	&& ./obj_dir/ddr_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log && echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }
